// File: tb.f
+incdir+verilog
verilog/tm1638_pkg.sv
verilog/audio_pkg.sv
verilog/tm_panel_if.sv
verilog/inmp441_i2s_receiver.sv
verilog/lab_control_regs.sv
verilog/level_display.sv
verilog/tm1638_board_controller.sv
verilog/board_top.sv
test/tb_panel_models.sv
test/tb_board_top.sv

// File: run.sh
#!/bin/sh
# Build and run the board testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_board_top \
    -f tb.f \
    -o Vtb_board_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_board_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
exit 1

// File: test/tb_board_top.sv
`timescale 1ns/1ns

module tb_board_top;

    localparam int LIMIT = 20000;   // clocks allowed per wait.

    typedef struct
    {
        string       name;
        logic [23:0] smp;
        logic [7:0]  keys;      // pressed, then released.
        logic        mode;
        logic        frz;
        logic [7:0]  leds;
    } row_t;

    logic clk;
    logic arst_n;
    logic sio_clk;
    logic sio_stb;
    logic sio_dout;
    logic sio_doe;
    logic sio_din;
    logic mic_sck;
    logic mic_ws;
    logic mic_sd;

    logic [7:0]       key_vec;
    logic [23:0]      mic_sample;
    logic [7:0][7:0]  digits;
    logic [7:0]       leds;
    int               frames;

    logic [7:0] seg_table [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                                   8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};

    row_t rows [17] = '{
        '{"raw_pos",     24'h012345, 8'h00, 1'b0, 1'b0, 8'h01},
        '{"raw_neg",     24'hFEDCBA, 8'h00, 1'b0, 1'b0, 8'h01},
        '{"bar_14",      24'h004000, 8'h00, 1'b0, 1'b0, 8'h00},
        '{"bar_16",      24'h010000, 8'h00, 1'b0, 1'b0, 8'h01},
        '{"bar_20",      24'h100000, 8'h00, 1'b0, 1'b0, 8'h1F},
        '{"bar_23",      24'h800000, 8'h00, 1'b0, 1'b0, 8'hFF},
        '{"mode_mag",    24'hFFF000, 8'h01, 1'b1, 1'b0, 8'h00},
        '{"mode_raw",    24'hFFF000, 8'h01, 1'b0, 1'b0, 8'h00},
        '{"freeze_on",   24'h123456, 8'h02, 1'b0, 1'b1, 8'h00},
        '{"freeze_hold", 24'h7FFFFF, 8'h00, 1'b0, 1'b1, 8'h00},
        '{"freeze_off",  24'h0ABCDE, 8'h02, 1'b0, 1'b0, 8'h0F},
        '{"key_2",       24'h000100, 8'h04, 1'b0, 1'b0, 8'h00},
        '{"key_3",       24'hFF0000, 8'h08, 1'b0, 1'b0, 8'h01},
        '{"key_4",       24'h020000, 8'h10, 1'b0, 1'b0, 8'h03},
        '{"key_5",       24'h040000, 8'h20, 1'b0, 1'b0, 8'h07},
        '{"key_6",       24'hF00000, 8'h40, 1'b0, 1'b0, 8'h1F},
        '{"key_7",       24'h400000, 8'h80, 1'b0, 1'b0, 8'h7F}
    };

    int          errors;
    int          passed;
    int          failed;
    logic [23:0] exp_held;

    board_top dut_i
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_dout ( sio_dout ),
        .sio_doe  ( sio_doe  ),
        .sio_din  ( sio_din  ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_sd   ( mic_sd   )
    );

    tm1638_model panel_i (sio_clk, sio_stb, sio_dout, sio_doe, key_vec,
                          sio_din, digits, leds, frames);

    inmp441_model mic_i (mic_sck, mic_ws, mic_sample, mic_sd);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [23:0] magnitude(input logic [23:0] v);
        return v[23] ? (~v + 24'd1) : v;
    endfunction

    function automatic logic [63:0] digits_of(input logic [23:0] v);
        logic [63:0] d;
        d = '0;     // digits 6 and 7 dark.
        for (int i = 0; i < 6; i++)
            d[8*i +: 8] = seg_table[v[23-4*i -: 4]];
        return d;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act)
        begin
            $display("ERROR %s expected %h actual %h", what, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string test, input string what);
        $display("timeout in %s: %s never came", test, what);
        $display("Something failed");
        $finish;
    endtask

    task automatic wait_frames(input int n, input string test);
        int start;
        int t;
        start = frames;
        t     = 0;
        while (frames < start + n)
        begin
            @(posedge clk);
            t++;
            if (t > LIMIT)
                report_timeout(test, "a panel display frame");
        end
    endtask

    // two falling ws edges guarantee a whole left slot of the new sample.
    task automatic wait_mic_frames(input int n, input string test);
        int   falls;
        int   t;
        logic prev;
        falls = 0;
        t     = 0;
        prev  = mic_ws;
        while (falls < n)
        begin
            @(posedge clk);
            t++;
            if (prev && !mic_ws)
                falls++;
            prev = mic_ws;
            if (t > LIMIT)
                report_timeout(test, "a microphone frame");
        end
    endtask

    task automatic run_row(input row_t r);
        int          err0;
        logic [23:0] shown;
        err0 = errors;
        if (r.keys != 8'h00)
        begin
            @(posedge clk);
            key_vec <= r.keys;
            wait_frames(2, r.name);
            @(posedge clk);
            key_vec <= 8'h00;
            wait_frames(2, r.name);
        end
        @(posedge clk);
        mic_sample <= r.smp;
        wait_mic_frames(2, r.name);
        wait_frames(2, r.name);

        if (!r.frz)
            exp_held = r.smp;   // frozen display keeps the old value.
        shown = r.mode ? magnitude(exp_held) : exp_held;

        check_value({r.name, " mode"}, 64'(r.mode), 64'(dut_i.i_control.mode));
        check_value({r.name, " freeze"}, 64'(r.frz), 64'(dut_i.i_control.freeze));
        check_value({r.name, " digits"}, digits_of(shown), digits);
        check_value({r.name, " leds"}, 64'(r.leds), 64'(leds));
        if (errors == err0)
        begin
            $display("PASS %s", r.name);
            passed++;
        end
        else
        begin
            $display("FAIL %s", r.name);
            failed++;
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial
    begin
        errors     = 0;
        passed     = 0;
        failed     = 0;
        exp_held   = '0;
        arst_n     = 1'b0;
        key_vec    = 8'h00;
        mic_sample = 24'h000000;

        repeat (3) @(posedge clk);
        check_value("reset sio_stb", 64'(1), 64'(sio_stb));
        check_value("reset sio_clk", 64'(1), 64'(sio_clk));
        check_value("reset sio_dout", 64'(1), 64'(sio_dout));
        check_value("reset sio_doe", 64'(1), 64'(sio_doe));
        check_value("reset mic_sck", 64'(0), 64'(mic_sck));
        check_value("reset mic_ws", 64'(0), 64'(mic_ws));
        arst_n <= 1'b1;

        // digit 0 of the first frame goes out before any sample lands.
        wait_frames(1, "reset_state");
        check_value("reset_state digit 0", 64'(0), 64'(digits[0]));
        check_value("reset_state digits 6..7", 64'(0), 64'({digits[7], digits[6]}));
        check_value("reset_state leds", 64'(0), 64'(leds));
        if (errors == 0)
        begin
            $display("PASS reset_state");
            passed++;
        end
        else
        begin
            $display("FAIL reset_state");
            failed++;
        end

        foreach (rows[i])
            run_row(rows[i]);

        $display("tests %0d passed %0d failed %0d", passed + failed, passed, failed);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: test/tb_panel_models.sv
`timescale 1ns/1ns

// ----------------------------------------
// tm1638 chip model
// ----------------------------------------

module tm1638_model
(
    input  logic             sio_clk,
    input  logic             sio_stb,
    input  logic             sio_dout,
    input  logic             sio_doe,
    input  logic [7:0]       keys,      // key i pressed when bit i is set.
    output logic             sio_din,
    output logic [7:0][7:0]  digits,    // digit i as last written.
    output logic [7:0]       leds,
    output int               frames     // completed display writes.
);

    logic [7:0] mem [16];
    logic [7:0] cmd;
    logic [7:0] shreg;
    logic [7:0] nb;
    logic [3:0] addr;
    int         bit_n;
    int         byte_n;

    initial
    begin
        cmd    = 8'h00;
        shreg  = 8'h00;
        addr   = 4'd0;
        bit_n  = 0;
        byte_n = 0;
        digits = '0;
        leds   = '0;
        frames = 0;
    end

    always @(negedge sio_stb)
    begin
        bit_n  = 0;
        byte_n = 0;
    end

    // a finished address transfer publishes the whole frame.
    always @(posedge sio_stb)
    begin
        if (cmd[7:6] == 2'b11 && byte_n > 1)
        begin
            for (int i = 0; i < 8; i++)
            begin
                digits[i] = mem[2*i];
                leds[i]   = mem[2*i+1][0];
            end
            frames = frames + 1;
        end
    end

    always @(posedge sio_clk)
    begin
        if (!sio_stb)
        begin
            nb = {sio_dout, shreg[7:1]};    // lsb first.
            if (sio_doe)
                shreg = nb;
            bit_n = bit_n + 1;
            if (bit_n == 8)
            begin
                bit_n = 0;
                if (byte_n == 0)
                begin
                    cmd = nb;
                    if (nb[7:6] == 2'b11)
                        addr = nb[3:0];
                end
                else if (cmd[7:6] == 2'b11 && sio_doe)
                begin
                    mem[addr] = nb;
                    addr      = addr + 4'd1;
                end
                byte_n = byte_n + 1;
            end
        end
    end

    // read byte b carries key b in bit 0 and key b+4 in bit 4.
    always @*
    begin
        sio_din = 1'b1;
        if (cmd == 8'h42 && byte_n >= 1 && byte_n <= 4)
        begin
            if (bit_n == 0)
                sio_din = keys[byte_n-1];
            else if (bit_n == 4)
                sio_din = keys[byte_n+3];
            else
                sio_din = 1'b0;
        end
    end

endmodule

// ----------------------------------------
// inmp441 microphone model
// ----------------------------------------

module inmp441_model
(
    input  logic        sck,
    input  logic        ws,
    input  logic [23:0] sample,
    output logic        sd
);

    int   pos;      // sck period within the frame.
    logic ws_d;

    initial
    begin
        pos  = 0;
        ws_d = 1'b0;
        sd   = 1'b0;
    end

    always @(negedge sck)
    begin
        #1;
        if (ws_d && !ws)
            pos = 0;    // new left slot.
        else
            pos = pos + 1;
        ws_d = ws;
        sd   = (pos >= 1 && pos <= 24) ? sample[24-pos] : 1'b0;
    end

endmodule

// File: verilog/board_top.sv
`timescale 1ns/1ns

module board_top
    import audio_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    output logic sio_clk,
    output logic sio_stb,
    output logic sio_dout,
    output logic sio_doe,
    input  logic sio_din,

    output logic mic_sck,
    output logic mic_ws,
    input  logic mic_sd
);

    tm_panel_if panel_if ();

    sample_t       sample;
    logic          sample_valid;
    display_mode_t mode;
    logic          freeze;

    // ----------------------------------------
    // microphone path
    // ----------------------------------------

    inmp441_i2s_receiver i_microphone
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .sd           ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    lab_control_regs i_control
    (
        .clk    ( clk      ),
        .arst_n ( arst_n   ),
        .panel  ( panel_if ),
        .mode   ( mode     ),
        .freeze ( freeze   )
    );

    level_display i_display
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .mode         ( mode         ),
        .freeze       ( freeze       ),
        .panel        ( panel_if     )
    );

    // ----------------------------------------
    // panel
    // ----------------------------------------

    tm1638_board_controller i_tm1638
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .panel    ( panel_if ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_dout ( sio_dout ),
        .sio_doe  ( sio_doe  ),
        .sio_din  ( sio_din  )
    );

endmodule

// File: verilog/tm1638_board_controller.sv
`timescale 1ns/1ns
`include "board_settings.svh"

module tm1638_board_controller
    import tm1638_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    tm_panel_if.ctrl panel,
    output logic     sio_clk,
    output logic     sio_stb,
    output logic     sio_dout,
    output logic     sio_doe,
    input  logic     sio_din
);

    localparam int W_DIV = (`SIO_DIV > 1) ? $clog2(`SIO_DIV) : 1;

    typedef enum logic [1:0]
    {
        ST_GAP,     // strobe high between transfers.
        ST_LOAD,    // strobe low, clock high, next byte pending.
        ST_BIT      // shifting a byte.
    } state_t;

    state_t                 state;
    logic [W_DIV-1:0]       div_cnt;
    logic                   half_tick;
    logic [1:0]             xfer;       // 0 mode, 1 address and data, 2 display, 3 keys.
    logic [4:0]             byte_idx;
    logic [4:0]             last_idx;
    logic [2:0]             bit_idx;
    logic                   gap_cnt;
    logic                   reading;
    logic [3:0]             data_idx;
    logic [1:0]             rd_idx;
    logic [7:0]             cur_byte;
    logic [7:0]             tx_byte;
    logic [7:0]             rd_shift;
    logic [`W_TM_DIGIT-1:0] key_acc;
    logic [`W_TM_DIGIT-1:0] key_nxt;
    logic                   load_evt;
    logic                   rise_evt;
    logic                   byte_end;

    assign half_tick = (div_cnt == W_DIV'(`SIO_DIV - 1));
    assign reading   = (xfer == 2'd3) && (byte_idx != 5'd0);
    assign data_idx  = 4'(byte_idx - 5'd1);
    assign rd_idx    = 2'(byte_idx - 5'd1);
    assign last_idx  = (xfer == 2'd1) ? 5'd16 : (xfer == 2'd3) ? 5'd4 : 5'd0;

    assign load_evt = half_tick && (state == ST_LOAD);
    assign rise_evt = half_tick && (state == ST_BIT) && !sio_clk;
    assign byte_end = half_tick && (state == ST_BIT) && sio_clk && (bit_idx == 3'd7);

    // ----------------------------------------
    // byte to send next
    // ----------------------------------------

    always_comb
    begin
        case (xfer)
            2'd0: cur_byte = TM_CMD_WRITE_AUTO;
            2'd1:
                if (byte_idx == 5'd0)
                    cur_byte = TM_CMD_ADDR0;
                else if (!data_idx[0])
                    cur_byte = panel.segs[data_idx[3:1]];   // even address, digit.
                else
                    cur_byte = {7'd0, panel.leds[data_idx[3:1]]};
            2'd2: cur_byte = TM_CMD_DISPLAY_ON;
            default: cur_byte = (byte_idx == 5'd0) ? TM_CMD_READ_KEYS : 8'hFF;
        endcase
    end

    // key i lives in bit (i/4)*4 of read byte i mod 4.
    always_comb
    begin
        key_nxt                = key_acc;
        key_nxt[{1'b0, rd_idx}] = rd_shift[0];
        key_nxt[{1'b1, rd_idx}] = rd_shift[4];
    end

    // ----------------------------------------
    // shift registers
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (load_evt)
            tx_byte <= cur_byte;
        if (rise_evt && reading)
            rd_shift <= {sio_din, rd_shift[7:1]};   // lsb arrives first.
        if (byte_end && reading)
            key_acc <= key_nxt;
    end

    // ----------------------------------------
    // refresh state machine
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state            <= ST_GAP;
            div_cnt          <= '0;
            xfer             <= 2'd0;
            byte_idx         <= 5'd0;
            bit_idx          <= 3'd0;
            gap_cnt          <= 1'b0;
            sio_clk          <= 1'b1;
            sio_stb          <= 1'b1;
            sio_dout         <= 1'b1;
            sio_doe          <= 1'b1;
            panel.keys       <= '0;
            panel.keys_valid <= 1'b0;
        end
        else
        begin
            panel.keys_valid <= 1'b0;
            div_cnt          <= half_tick ? '0 : div_cnt + 1'b1;

            if (half_tick)
            begin
                case (state)
                    ST_GAP:
                    begin
                        gap_cnt <= ~gap_cnt;
                        if (gap_cnt)    // two half periods high.
                        begin
                            sio_stb <= 1'b0;
                            state   <= ST_LOAD;
                        end
                    end
                    ST_LOAD:
                    begin
                        sio_clk  <= 1'b0;
                        sio_dout <= cur_byte[0];
                        sio_doe  <= !reading;   // chip drives data on reads.
                        bit_idx  <= 3'd0;
                        state    <= ST_BIT;
                    end
                    default:
                    begin
                        if (!sio_clk)
                            sio_clk <= 1'b1;    // chip samples here.
                        else if (bit_idx != 3'd7)
                        begin
                            sio_clk  <= 1'b0;
                            sio_dout <= tx_byte[bit_idx + 3'd1];
                            bit_idx  <= bit_idx + 3'd1;
                        end
                        else if (byte_idx != last_idx)
                        begin
                            byte_idx <= byte_idx + 5'd1;
                            state    <= ST_LOAD;
                        end
                        else
                        begin
                            sio_stb  <= 1'b1;   // end of transfer.
                            sio_dout <= 1'b1;
                            sio_doe  <= 1'b1;
                            byte_idx <= 5'd0;
                            xfer     <= xfer + 2'd1;
                            state    <= ST_GAP;
                            if (reading)
                            begin
                                panel.keys       <= key_nxt;
                                panel.keys_valid <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/level_display.sv
`timescale 1ns/1ns
`include "board_settings.svh"

module level_display
    import tm1638_pkg::*;
    import audio_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  sample_t       sample,
    input  logic          sample_valid,
    input  display_mode_t mode,
    input  logic          freeze,
    tm_panel_if.disp      panel
);

    localparam int N_HEX = `W_SAMPLE / 4;   // hex digits in use.

    logic                   have_sample;
    sample_t                held;
    logic [`W_SAMPLE-1:0]   mag;
    logic [`W_SAMPLE-1:0]   shown;
    seg_array_t             segs_nxt;
    logic [`W_TM_DIGIT-1:0] leds_nxt;
    int                     bar_n;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic seg_t hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    // top set bit minus 15, clipped to the led count.
    function automatic int bar_len(input logic [`W_SAMPLE-1:0] m);
        int top;
        int len;
        top = -1;
        for (int i = 0; i < `W_SAMPLE; i++)
        begin
            if (m[i])
                top = i;
        end
        len = top - 15;
        if (len < 0)
            len = 0;
        if (len > `W_TM_DIGIT)
            len = `W_TM_DIGIT;
        return len;
    endfunction

    // ----------------------------------------
    // value selection and encoding
    // ----------------------------------------

    assign mag   = held[`W_SAMPLE-1] ? -held : held;
    assign shown = (mode == MODE_MAG) ? mag : held;
    assign bar_n = bar_len(mag);

    always_comb
    begin
        segs_nxt = {`W_TM_DIGIT{SEG_BLANK}};    // digits past the hex ones stay dark.
        for (int d = 0; d < N_HEX; d++)
            segs_nxt[d] = hex_seg(shown[`W_SAMPLE-1-4*d -: 4]);

        for (int i = 0; i < `W_TM_DIGIT; i++)
            leds_nxt[i] = (i < bar_n);
    end

    // ----------------------------------------
    // sample hold and outputs
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (sample_valid && !freeze)
            held <= sample;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            have_sample <= 1'b0;
            panel.segs  <= {`W_TM_DIGIT{SEG_BLANK}};
            panel.leds  <= '0;
        end
        else
        begin
            if (sample_valid && !freeze)
                have_sample <= 1'b1;
            if (have_sample)
            begin
                panel.segs <= segs_nxt;
                panel.leds <= leds_nxt;
            end
        end
    end

endmodule

// File: verilog/lab_control_regs.sv
`timescale 1ns/1ns
`include "board_settings.svh"

module lab_control_regs
    import audio_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    tm_panel_if.keys_in    panel,
    output display_mode_t  mode,
    output logic           freeze
);

    logic [`W_TM_DIGIT-1:0] keys_prev;  // snapshot from the last refresh.
    logic [`W_TM_DIGIT-1:0] key_rise;

    // a key counts as pressed once, when it goes from up to down.
    assign key_rise = panel.keys & ~keys_prev;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            keys_prev <= '0;
            mode      <= MODE_RAW;
            freeze    <= 1'b0;
        end
        else if (panel.keys_valid)
        begin
            keys_prev <= panel.keys;

            if (key_rise[0])
                mode <= (mode == MODE_RAW) ? MODE_MAG : MODE_RAW;

            if (key_rise[1])
                freeze <= ~freeze;  // hold the display.
        end
    end

endmodule

// File: verilog/inmp441_i2s_receiver.sv
`timescale 1ns/1ns
`include "board_settings.svh"

module inmp441_i2s_receiver
    import audio_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    output logic    sck,
    output logic    ws,
    input  logic    sd,
    output sample_t sample,
    output logic    sample_valid
);

    localparam int W_DIV = (`SCK_DIV > 1) ? $clog2(`SCK_DIV) : 1;

    logic [W_DIV-1:0]     div_cnt;
    logic                 sck_tick;     // last clock of an sck half period.
    logic [5:0]           bit_cnt;      // sck period within the frame.
    logic [5:0]           bit_cnt_nxt;
    logic                 take_bit;
    logic [`W_SAMPLE-1:0] shift_reg;
    logic                 capture_done;

    assign sck_tick    = (div_cnt == W_DIV'(`SCK_DIV - 1));
    assign bit_cnt_nxt = bit_cnt + 6'd1;

    // msb sits in the second bit of the left slot.
    assign take_bit = sck_tick && !sck
                   && (bit_cnt >= 6'd1) && (bit_cnt <= 6'(`W_SAMPLE));

    // ----------------------------------------
    // sck and ws generation
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
            bit_cnt <= 6'd0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
            if (sck)    // falling edge of sck.
            begin
                bit_cnt <= bit_cnt_nxt;
                ws      <= bit_cnt_nxt[5];    // high for the right slot.
            end
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ----------------------------------------
    // data capture
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (take_bit)
            shift_reg <= {shift_reg[`W_SAMPLE-2:0], sd};   // msb first.
        if (capture_done)
            sample <= shift_reg;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            capture_done <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            capture_done <= take_bit && (bit_cnt == 6'(`W_SAMPLE));
            sample_valid <= capture_done;
        end
    end

endmodule

// File: verilog/tm_panel_if.sv
`timescale 1ns/1ns
`include "board_settings.svh"

interface tm_panel_if
    import tm1638_pkg::*;
();

    seg_array_t              segs;          // digit patterns to show.
    logic [`W_TM_DIGIT-1:0]  leds;          // one bit per led.
    logic [`W_TM_DIGIT-1:0]  keys;          // last key snapshot.
    logic                    keys_valid;    // new snapshot, one clock.

    modport ctrl    (input segs, input leds, output keys, output keys_valid);
    modport disp    (output segs, output leds);
    modport keys_in (input keys, input keys_valid);

endinterface

// File: verilog/audio_pkg.sv
`include "board_settings.svh"

package audio_pkg;

    // one microphone sample, two's complement.
    typedef logic signed [`W_SAMPLE-1:0] sample_t;

    // what the six hex digits show.
    typedef enum logic
    {
        MODE_RAW = 1'b0,    // raw sample.
        MODE_MAG = 1'b1     // absolute value.
    } display_mode_t;

endpackage

// File: verilog/tm1638_pkg.sv
`include "board_settings.svh"

package tm1638_pkg;

    // one digit, bit order hgfedcba, h is the decimal point.
    typedef logic [7:0] seg_t;

    // all digits of the panel, digit 0 is the leftmost one.
    typedef seg_t [`W_TM_DIGIT-1:0] seg_array_t;

    localparam seg_t SEG_BLANK = 8'h00;

    // ----------------------------------------
    // command bytes
    // ----------------------------------------

    localparam logic [7:0] TM_CMD_WRITE_AUTO = 8'h40;  // data write, auto increment.
    localparam logic [7:0] TM_CMD_ADDR0      = 8'hC0;  // start at display address 0.
    localparam logic [7:0] TM_CMD_DISPLAY_ON = 8'h8F;  // display on, full brightness.
    localparam logic [7:0] TM_CMD_READ_KEYS  = 8'h42;  // key scan readback.

endpackage

// File: verilog/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// ----------------------------------------
// board clock and serial dividers
// ----------------------------------------

`define CLK_MHZ     27
`define SIO_DIV     4       // clocks per half period of sio_clk.
`define SCK_DIV     4       // clocks per half period of mic sck.

// ----------------------------------------
// data widths
// ----------------------------------------

`define W_SAMPLE    24      // microphone sample bits.
`define W_TM_DIGIT  8       // panel digits, keys and leds.

`endif
